// ==== hw/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// 5x5 window
// the adder tree shape is fixed to this tap count
`define CONV_TAPS 25

// sample width for pixels, weights and results
`define CONV_DWIDTH 16

// fraction bits of the fixed-point format
// 8 fraction bits give a 1.0 of 256
`define CONV_FRAC 8

`endif

// ==== hw/conv_pkg.sv ====
`include "conv_settings.svh"

package conv_pkg;

  // signed fixed-point sample
  // used for pixels, weights, rounded products and fmap
  typedef logic signed [`CONV_DWIDTH-1:0] sample_t;

  // full product of two samples, 2*DWIDTH bits
  // read as a whole number, or split up for rounding
  typedef union packed {
    // signed product as the multiplier gives it
    logic signed [2*`CONV_DWIDTH-1:0] raw;

    // bit fields for reduction to one sample
    struct packed {
      // above the kept range, dropped
      logic [`CONV_DWIDTH-`CONV_FRAC:0] high;
      // kept bits, top one acts as sign
      logic [`CONV_DWIDTH-2:0]          kept;
      // below the binary point
      logic [`CONV_FRAC-1:0]            frac;
    } fields;
  } product_u;

endpackage

// ==== hw/tap_product.sv ====
`timescale 1ns/1ns
`include "conv_settings.svh"

module tap_product (
  input  logic              clk,
  input  logic              xrst,
  input  conv_pkg::sample_t pixel,
  input  conv_pkg::sample_t weight,
  output conv_pkg::sample_t rounded
);
  import conv_pkg::*;

  sample_t                 pixel_q;
  sample_t                 weight_q;
  product_u                prod_d;
  product_u                prod_q;
  logic                    kept_sign;
  logic                    exact;
  logic [`CONV_DWIDTH-2:0] kept_adj;
  sample_t                 round_d;

  //////////////////////////////
  // input registers
  //////////////////////////////

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      pixel_q  <= '0;
      weight_q <= '0;
    end else begin
      pixel_q  <= pixel;
      weight_q <= weight;
    end
  end

  //////////////////////////////
  // full product
  //////////////////////////////

  // both operands are signed so the 32-bit result keeps its sign
  always_comb begin
    prod_d.raw = pixel_q * weight_q;
  end

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      prod_q <= '0;
    end else begin
      prod_q <= prod_d;
    end
  end

  //////////////////////////////
  // reduction to 16 bits
  //////////////////////////////

  assign kept_sign = prod_q.fields.kept[`CONV_DWIDTH-2];
  assign exact     = (prod_q.fields.frac == '0);

  // negative with a clean fraction steps down by one lsb
  always_comb begin
    kept_adj = prod_q.fields.kept;
    if (kept_sign && exact) begin
      kept_adj = prod_q.fields.kept - 1'b1;
    end
  end

  assign round_d = {kept_sign, kept_adj};

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      rounded <= '0;
    end else begin
      rounded <= round_d;
    end
  end

  // top two bits follow the sign unless the decrement borrowed through
  assert property (@(posedge clk) disable iff (!xrst)
    !$past(exact && prod_q.fields.kept[`CONV_DWIDTH-3:0] == '0)
      |-> rounded[`CONV_DWIDTH-1 -: 2] == {2{$past(kept_sign)}});

endmodule

// ==== hw/adder_tree.sv ====
`timescale 1ns/1ns
`include "conv_settings.svh"

module adder_tree (
  input  logic              clk,
  input  logic              xrst,
  input  conv_pkg::sample_t products [`CONV_TAPS],
  output conv_pkg::sample_t fmap
);
  import conv_pkg::*;

  // taps 0..23 go through the tree, the last one bypasses it
  localparam int N_PAIR = (`CONV_TAPS - 1) / 2;
  localparam int N_QUAD = N_PAIR / 2;
  localparam int N_OCT  = N_QUAD / 2;

  sample_t pair_sum [N_PAIR];
  sample_t quad_sum [N_QUAD];
  sample_t oct_sum  [N_OCT];
  sample_t oct_q    [N_OCT];
  sample_t last_q;
  sample_t sum_lo;
  sample_t sum_hi;
  sample_t fmap_d;

  //////////////////////////////
  // first half, three levels
  //////////////////////////////

  // neighbouring taps
  for (genvar i = 0; i < N_PAIR; i++) begin : g_pair
    assign pair_sum[i] = products[2*i+1] + products[2*i];
  end

  // pairs of pairs
  for (genvar i = 0; i < N_QUAD; i++) begin : g_quad
    assign quad_sum[i] = pair_sum[2*i+1] + pair_sum[2*i];
  end

  // groups of eight taps
  for (genvar i = 0; i < N_OCT; i++) begin : g_oct
    assign oct_sum[i] = quad_sum[2*i+1] + quad_sum[2*i];
  end

  // pipeline cut
  // odd tap is held here so it lines up with the group sums
  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      for (int i = 0; i < N_OCT; i++) begin
        oct_q[i] <= '0;
      end
      last_q <= '0;
    end else begin
      for (int i = 0; i < N_OCT; i++) begin
        oct_q[i] <= oct_sum[i];
      end
      last_q <= products[`CONV_TAPS-1];
    end
  end

  //////////////////////////////
  // second half, two levels
  //////////////////////////////

  assign sum_lo = oct_q[0] + oct_q[1];
  assign sum_hi = oct_q[2] + last_q;

  // wraps at 16 bits, no saturation
  assign fmap_d = sum_lo + sum_hi;

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      fmap <= '0;
    end else begin
      fmap <= fmap_d;
    end
  end

  // reset flushes both stages, so fmap is known after two edges
  assert property (@(posedge clk)
    xrst && $past(xrst) && $past(xrst, 2) |-> !$isunknown(fmap));

endmodule

// ==== hw/conv_tree.sv ====
`timescale 1ns/1ns
`include "conv_settings.svh"

module conv_tree (
  input  logic              clk,
  input  logic              xrst,
  input  conv_pkg::sample_t pixel  [`CONV_TAPS],
  input  conv_pkg::sample_t weight [`CONV_TAPS],
  output conv_pkg::sample_t fmap
);
  import conv_pkg::*;

  // rounded product per tap, three edges after sampling
  sample_t products [`CONV_TAPS];

  //////////////////////////////
  // taps
  //////////////////////////////

  for (genvar i = 0; i < `CONV_TAPS; i++) begin : g_tap
    tap_product u_tap_product (
      .clk     (clk),
      .xrst    (xrst),
      .pixel   (pixel[i]),
      .weight  (weight[i]),
      .rounded (products[i])
    );
  end

  //////////////////////////////
  // reduction
  //////////////////////////////

  // two more edges to fmap
  adder_tree u_adder_tree (
    .clk      (clk),
    .xrst     (xrst),
    .products (products),
    .fmap     (fmap)
  );

endmodule

// ==== dv/tb_conv_tree.sv ====
`timescale 1ns/1ns
`include "conv_settings.svh"

module tb_conv_tree;
  import conv_pkg::*;

  localparam int      TAPS          = `CONV_TAPS;
  localparam int      FRAC          = `CONV_FRAC;
  localparam int      KEEP_HI       = `CONV_DWIDTH + `CONV_FRAC - 2;
  localparam int      LATENCY       = 5;
  localparam int      RESET_TIMEOUT = 20;
  localparam int      DRAIN_TIMEOUT = 20;
  localparam sample_t ONE           = sample_t'(1 << FRAC);

  logic    clk = 1'b0;
  logic    xrst;
  sample_t pixel  [TAPS];
  sample_t weight [TAPS];
  sample_t fmap;

  // window under construction
  sample_t px [TAPS];
  sample_t wt [TAPS];

  // expected values, due cycle and label per driven window
  sample_t exp_q [$];
  int      due_q [$];
  string   tag_q [$];

  integer seed;
  int     cycle       = 0;
  int     checks      = 0;
  int     errors      = 0;
  int     timeouts    = 0;
  int     test_checks = 0;
  int     test_errors = 0;

  conv_tree u_conv_tree (
    .clk    (clk),
    .xrst   (xrst),
    .pixel  (pixel),
    .weight (weight),
    .fmap   (fmap)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  initial begin
    xrst <= 1'b0;
    repeat (8) @(posedge clk);
    xrst <= 1'b1;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // full product keeps bits 22..8 and negative exact products step down
  function automatic sample_t ref_fmap(input sample_t p [TAPS], input sample_t w [TAPS]);
    logic signed [31:0] prod;
    logic [14:0]        kept;
    sample_t            acc;
    acc = '0;
    for (int i = 0; i < TAPS; i++) begin
      prod = 32'(p[i]) * 32'(w[i]);
      kept = prod[KEEP_HI:FRAC];
      if (prod[KEEP_HI] && prod[FRAC-1:0] == '0) begin
        kept = kept - 1'b1;
      end
      // wraps at 16 bits
      acc = acc + {prod[KEEP_HI], kept};
    end
    return acc;
  endfunction

  function automatic sample_t rand_word();
    int r;
    r = $random(seed);
    return sample_t'(r[15:0]);
  endfunction

  //////////////////////////////
  // checking
  //////////////////////////////

  task automatic check_value(input sample_t got, input sample_t expected, input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[FAIL] %0t ns: %s, fmap %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // fmap settles after the edge and is read half a cycle later
  always @(negedge clk) begin : compare
    sample_t exp_v;
    string   tag_v;
    int      due_v;
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      exp_v = exp_q.pop_front();
      tag_v = tag_q.pop_front();
      due_v = due_q.pop_front();
      if (due_v < cycle) begin
        errors++;
        $display("window '%s' was not compared in its due cycle", tag_v);
      end else begin
        check_value(fmap, exp_v, tag_v);
      end
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic clear_window();
    for (int i = 0; i < TAPS; i++) begin
      px[i] = '0;
      wt[i] = '0;
    end
  endtask

  task automatic drive_window(input sample_t expected, input string tag);
    @(posedge clk);
    for (int i = 0; i < TAPS; i++) begin
      pixel[i]  <= px[i];
      weight[i] <= wt[i];
    end
    exp_q.push_back(expected);
    // cycle still holds the count before this edge
    due_q.push_back(cycle + LATENCY + 1);
    tag_q.push_back(tag);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (xrst !== 1'b1 && n < RESET_TIMEOUT) begin
      @(negedge clk);
      check_value(fmap, '0, "fmap during reset");
      n++;
    end
    if (xrst !== 1'b1) begin
      timeouts++;
      $display("timeout: reset still active after %0d cycles", RESET_TIMEOUT);
    end
  endtask

  task automatic drain_queue();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("timeout: %0d expected values still waiting after %0d cycles",
               exp_q.size(), DRAIN_TIMEOUT);
    end
  endtask

  task automatic end_test(input string name);
    drain_queue();
    $display("test %s checks %0d, errors %0d", name,
             checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    sample_t w;
    seed = 32'heb37;
    for (int i = 0; i < TAPS; i++) begin
      pixel[i]  <= '0;
      weight[i] <= '0;
    end
    clear_window();

    // zero during reset and right after it
    wait_reset_release();
    repeat (6) drive_window('0, "idle after reset");
    end_test("reset");

    // 1.0 on one tap passes the pixel through on every tap including 24
    for (int t = 0; t < TAPS; t++) begin
      clear_window();
      w = rand_word();
      px[t] = {2'b00, w[13:0]};
      if (px[t] == '0) begin
        px[t] = 16'sd1;
      end
      wt[t] = ONE;
      drive_window(px[t], $sformatf("one-hot tap %0d", t));
    end
    end_test("one_hot");

    // negative exact product loses one lsb
    for (int t = 0; t < TAPS; t++) begin
      clear_window();
      w = rand_word();
      px[t] = {2'b11, w[13:0]};
      wt[t] = ONE;
      drive_window(px[t] - 16'sd1, $sformatf("negative exact, tap %0d", t));
    end
    // half weight on an odd pixel leaves a fraction and so no decrement
    for (int t = 0; t < TAPS; t++) begin
      clear_window();
      w = rand_word();
      px[t] = {2'b11, w[13:1], 1'b1};
      wt[t] = ONE >>> 1;
      drive_window(px[t] >>> 1, $sformatf("negative inexact, tap %0d", t));
    end
    end_test("rounding");

    // full range with a new window every cycle
    for (int n = 0; n < 300; n++) begin
      for (int i = 0; i < TAPS; i++) begin
        px[i] = rand_word();
        wt[i] = rand_word();
      end
      drive_window(ref_fmap(px, wt), $sformatf("random window %0d", n));
    end
    end_test("random");

    // sums past the 16-bit range
    for (int i = 0; i < TAPS; i++) begin
      px[i] = 16'sd16000;
      wt[i] = ONE;
    end
    drive_window(sample_t'(TAPS * 16000), "wrap all positive");
    for (int i = 0; i < TAPS; i++) begin
      px[i] = -16'sd16000;
    end
    drive_window(sample_t'(-TAPS * 16001), "wrap all negative");
    for (int n = 0; n < 40; n++) begin
      for (int i = 0; i < TAPS; i++) begin
        w = rand_word();
        px[i] = {w[15], ~w[15], w[13:0]};
        w = rand_word();
        wt[i] = {7'b0000000, 1'b1, w[7:0]};
      end
      drive_window(ref_fmap(px, wt), $sformatf("large window %0d", n));
    end
    end_test("wrap");

    $display("checks %0d, passed %0d, failed %0d, timeouts %0d",
             checks, checks - errors, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/conv_pkg.sv
hw/tap_product.sv
hw/adder_tree.sv
hw/conv_tree.sv
dv/tb_conv_tree.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the conv_tree testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f \
  --top-module tb_conv_tree \
  -o tb_conv_tree

./obj_dir/tb_conv_tree > "$LOG" 2>&1 || {
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
}

cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

exit 0
